//--- logic/tracker_pkg.sv
package tracker_pkg;

    // raster positions and pixel colour
    typedef logic [10:0] h_pos_t;
    typedef logic [9:0]  v_pos_t;
    typedef logic [11:0] rgb_t;  // 4 bits per channel with r in the top nibble

    ////////////////////
    // display timing for 1024x768 at 65 MHz
    localparam h_pos_t H_ACTIVE = 11'd1024;
    localparam h_pos_t H_FRONT  = 11'd24;
    localparam h_pos_t H_SYNC   = 11'd136;
    localparam h_pos_t H_BACK   = 11'd160;
    localparam h_pos_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 1344

    localparam v_pos_t V_ACTIVE = 10'd768;
    localparam v_pos_t V_FRONT  = 10'd3;
    localparam v_pos_t V_SYNC   = 10'd6;
    localparam v_pos_t V_BACK   = 10'd29;
    localparam v_pos_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 806

    // camera image sits in the top left corner
    localparam h_pos_t CAM_H = 11'd640;
    localparam v_pos_t CAM_V = 10'd480;

    ////////////////////
    // tracking regions with inclusive bounds
    localparam h_pos_t BALL_H_LO   = 11'd20;
    localparam h_pos_t BALL_H_HI   = 11'd319;
    localparam h_pos_t TGT_H_LO    = 11'd320;
    localparam h_pos_t TGT_H_HI    = 11'd639;
    localparam v_pos_t REGION_V_LO = 10'd50;
    localparam v_pos_t REGION_V_HI = 10'd400;

    localparam v_pos_t DEADBAND = 10'd2;  // lines

    // centroid arithmetic
    localparam int SUM_BITS = 27;  // also the divider iteration count
    typedef logic [SUM_BITS-1:0] sum_t;
    typedef logic [16:0] count_t;

endpackage

//--- logic/raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    output tracker_pkg::h_pos_t hcount,
    output tracker_pkg::v_pos_t vcount,
    output logic                hsync,
    output logic                vsync,
    output logic                blank
);
    import tracker_pkg::*;

    localparam h_pos_t HS_START = H_ACTIVE + H_FRONT;
    localparam h_pos_t HS_END   = HS_START + H_SYNC;
    localparam v_pos_t VS_START = V_ACTIVE + V_FRONT;
    localparam v_pos_t VS_END   = VS_START + V_SYNC;

    h_pos_t h_next;
    v_pos_t v_next;
    logic   line_end;

    always_comb begin
        line_end = (hcount == H_TOTAL - 1'b1);
        h_next   = line_end ? '0 : hcount + 1'b1;
        if (!line_end)
            v_next = vcount;
        else if (vcount == V_TOTAL - 1'b1)
            v_next = '0;  // wrap to the top of the frame
        else
            v_next = vcount + 1'b1;
    end

    // syncs and blank come from the next position so they line up with the counters
    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            blank  <= 1'b0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            hsync  <= (h_next >= HS_START) && (h_next < HS_END);
            vsync  <= (v_next >= VS_START) && (v_next < VS_END);
            blank  <= (h_next >= H_ACTIVE) || (v_next >= V_ACTIVE);
        end
    end

    // the pixel counter stays inside one line period
    a_hcount_range: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        hcount < H_TOTAL);

endmodule

//--- logic/color_filter.sv
`timescale 1ns/1ps

module color_filter #(
    parameter logic [3:0] R_LO = 4'd8,
    parameter logic [3:0] R_HI = 4'd15,
    parameter logic [3:0] G_LO = 4'd0,
    parameter logic [3:0] G_HI = 4'd5,
    parameter logic [3:0] B_LO = 4'd0,
    parameter logic [3:0] B_HI = 4'd5
) (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    input  tracker_pkg::rgb_t   pixel_rgb,
    input  tracker_pkg::h_pos_t pixel_h,
    input  tracker_pkg::v_pos_t pixel_v,
    output logic                hit,
    output tracker_pkg::h_pos_t hit_h,
    output tracker_pkg::v_pos_t hit_v
);
    import tracker_pkg::*;

    h_pos_t     h_d1;  // position that pixel_rgb belongs to
    v_pos_t     v_d1;
    logic [3:0] r, g, b;
    logic       in_cam;
    logic       match;

    assign r = pixel_rgb[11:8];
    assign g = pixel_rgb[7:4];
    assign b = pixel_rgb[3:0];

    assign in_cam = (h_d1 < CAM_H) && (v_d1 < CAM_V);  // black outside the camera
    assign match  = (r >= R_LO) && (r <= R_HI) && (g >= G_LO) && (g <= G_HI) &&
                    (b >= B_LO) && (b <= B_HI);

    always_ff @(posedge clk_65mhz) begin
        h_d1  <= pixel_h;
        v_d1  <= pixel_v;
        hit_h <= h_d1;
        hit_v <= v_d1;
    end

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n)
            hit <= 1'b0;
        else
            hit <= in_cam && match;
    end

endmodule

//--- logic/centroid_accumulator.sv
`timescale 1ns/1ps

module centroid_accumulator #(
    parameter type pos_t = tracker_pkg::h_pos_t
) (
    input  logic clk_65mhz,
    input  logic rst_n,
    input  logic frame_done,
    input  logic sample,
    input  pos_t pos,
    output logic ready,
    output pos_t avg
);
    import tracker_pkg::*;

    localparam int CNT_BITS  = $bits(count_t);
    localparam int ITER_BITS = $clog2(SUM_BITS + 1);
    localparam logic [ITER_BITS-1:0] LAST_ITER = ITER_BITS'(SUM_BITS - 1);

    sum_t                 sum_acc;  // running sums for the frame in progress
    count_t               cnt_acc;
    logic                 busy;
    logic                 div_zero;  // no samples, so the result is forced to 0
    logic [ITER_BITS-1:0] iter;

    count_t               rem;
    count_t               divisor;
    sum_t                 quo;  // dividend bits shift out the top, quotient in the bottom
    logic [CNT_BITS:0]    trial;
    logic                 take;
    sum_t                 quo_next;

    ////////////////////
    // one restoring step per cycle
    always_comb begin
        trial    = {rem, quo[SUM_BITS-1]};
        take     = (trial >= {1'b0, divisor});
        quo_next = {quo[SUM_BITS-2:0], take};
    end

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            sum_acc  <= '0;
            cnt_acc  <= '0;
            busy     <= 1'b0;
            div_zero <= 1'b0;
            iter     <= '0;
            ready    <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (frame_done) begin
                sum_acc  <= '0;
                cnt_acc  <= '0;
                busy     <= 1'b1;
                div_zero <= (cnt_acc == '0);
                iter     <= '0;
            end else begin
                if (sample) begin
                    sum_acc <= sum_acc + sum_t'(pos);
                    cnt_acc <= cnt_acc + 1'b1;
                end
                if (busy) begin
                    iter <= iter + 1'b1;
                    if (iter == LAST_ITER) begin
                        busy  <= 1'b0;
                        ready <= 1'b1;  // avg is valid with this pulse
                    end
                end
            end
        end
    end

    ////////////////////
    // divider datapath
    always_ff @(posedge clk_65mhz) begin
        if (frame_done) begin
            quo     <= sum_acc;
            divisor <= cnt_acc;
            rem     <= '0;
        end else if (busy) begin
            quo <= quo_next;
            rem <= take ? count_t'(trial - {1'b0, divisor}) : count_t'(trial);
            if (iter == LAST_ITER)
                avg <= div_zero ? '0 : pos_t'(quo_next);
        end
    end

    // frames are far longer than a divide, so a new frame end never finds it busy
    a_no_overlap: assert property (@(posedge clk_65mhz) disable iff (!rst_n)
        frame_done |-> !busy);

endmodule

//--- logic/tracking_controller.sv
`timescale 1ns/1ps

module tracking_controller (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    input  tracker_pkg::h_pos_t hcount,
    input  tracker_pkg::v_pos_t vcount,
    input  logic                hit,
    input  tracker_pkg::h_pos_t hit_h,
    input  tracker_pkg::v_pos_t hit_v,
    input  logic                ball_h_ready,
    input  logic                ball_v_ready,
    input  logic                tgt_h_ready,
    input  logic                tgt_v_ready,
    input  tracker_pkg::h_pos_t ball_h_avg,
    input  tracker_pkg::v_pos_t ball_v_avg,
    input  tracker_pkg::h_pos_t tgt_h_avg,
    input  tracker_pkg::v_pos_t tgt_v_avg,
    output logic                ball_hit,
    output logic                target_hit,
    output logic                frame_done,
    output tracker_pkg::h_pos_t ball_h,
    output tracker_pkg::v_pos_t ball_v,
    output tracker_pkg::h_pos_t target_h,
    output tracker_pkg::v_pos_t target_v,
    output logic                result_valid,
    output logic                ball_low,
    output logic                ball_high,
    output logic                ball_centered
);
    import tracker_pkg::*;

    logic in_rows;
    logic all_ready;
    logic below;
    logic above;

    ////////////////////
    // region tests on the filtered pixel
    assign in_rows    = (hit_v >= REGION_V_LO) && (hit_v <= REGION_V_HI);
    assign ball_hit   = hit && in_rows && (hit_h >= BALL_H_LO) && (hit_h <= BALL_H_HI);
    assign target_hit = hit && in_rows && (hit_h >= TGT_H_LO) && (hit_h <= TGT_H_HI);

    assign all_ready = ball_h_ready && ball_v_ready && tgt_h_ready && tgt_v_ready;

    // larger line number is lower on screen
    assign below = (tgt_v_avg + DEADBAND) < ball_v_avg;
    assign above = (ball_v_avg + DEADBAND) < tgt_v_avg;

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            frame_done    <= 1'b0;
            ball_h        <= '0;
            ball_v        <= '0;
            target_h      <= '0;
            target_v      <= '0;
            result_valid  <= 1'b0;
            ball_low      <= 1'b0;
            ball_high     <= 1'b0;
            ball_centered <= 1'b0;
        end else begin
            frame_done   <= (hcount == '0) && (vcount == '0);  // top left starts a new frame
            result_valid <= all_ready;
            if (all_ready) begin
                ball_h        <= ball_h_avg;
                ball_v        <= ball_v_avg;
                target_h      <= tgt_h_avg;
                target_v      <= tgt_v_avg;
                ball_low      <= below;
                ball_high     <= above;
                ball_centered <= !below && !above;
            end
        end
    end

endmodule

//--- logic/overlay_mixer.sv
`timescale 1ns/1ps

module overlay_mixer #(
    parameter int BOX_RADIUS = 15
) (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    input  tracker_pkg::h_pos_t hcount,
    input  tracker_pkg::v_pos_t vcount,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                blank,
    input  tracker_pkg::rgb_t   pixel_rgb,
    input  logic                hit,
    input  tracker_pkg::h_pos_t ball_h,
    input  tracker_pkg::v_pos_t ball_v,
    input  tracker_pkg::h_pos_t target_h,
    input  tracker_pkg::v_pos_t target_v,
    input  logic                show_mask,
    input  logic                show_markers,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hs,
    output logic                vga_vs
);
    import tracker_pkg::*;

    h_pos_t h1, h2;
    v_pos_t v1, v2;
    logic   hs1, hs2, vs1, vs2, bl1, bl2;
    rgb_t   rgb2;  // camera pixel aligned with hit
    rgb_t   cam_px;
    rgb_t   px;

    // true on the outline of the square around a centre
    function automatic logic on_outline(input h_pos_t h, input v_pos_t v,
                                        input h_pos_t ch, input v_pos_t cv);
        int dh;
        int dv;
        dh = int'(h) - int'(ch);
        dv = int'(v) - int'(cv);
        dh = (dh < 0) ? -dh : dh;
        dv = (dv < 0) ? -dv : dv;
        return (dh <= BOX_RADIUS) && (dv <= BOX_RADIUS) &&
               ((dh == BOX_RADIUS) || (dv == BOX_RADIUS));
    endfunction

    assign cam_px = ((h2 < CAM_H) && (v2 < CAM_V)) ? rgb2 : '0;

    always_comb begin
        if (show_mask && hit)
            px = 12'h0F0;
        else if (show_markers && on_outline(h2, v2, ball_h, ball_v))
            px = 12'hF00;
        else if (show_markers && on_outline(h2, v2, target_h, target_v))
            px = 12'h00F;
        else
            px = cam_px;
    end

    ////////////////////
    always_ff @(posedge clk_65mhz) begin
        h1   <= hcount;
        v1   <= vcount;
        h2   <= h1;
        v2   <= v1;
        rgb2 <= pixel_rgb;
    end

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            {hs1, vs1, bl1} <= 3'b000;
            {hs2, vs2, bl2} <= 3'b000;
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs <= 1'b1;  // syncs are active low on the connector
            vga_vs <= 1'b1;
        end else begin
            {hs1, vs1, bl1} <= {hsync, vsync, blank};
            {hs2, vs2, bl2} <= {hs1, vs1, bl1};
            {vga_r, vga_g, vga_b} <= bl2 ? 12'h000 : px;
            vga_hs <= ~hs2;
            vga_vs <= ~vs2;
        end
    end

endmodule

//--- logic/tracker_top.sv
`timescale 1ns/1ps

module tracker_top #(
    parameter logic [3:0] R_LO       = 4'd8,
    parameter logic [3:0] R_HI       = 4'd15,
    parameter logic [3:0] G_LO       = 4'd0,
    parameter logic [3:0] G_HI       = 4'd5,
    parameter logic [3:0] B_LO       = 4'd0,
    parameter logic [3:0] B_HI       = 4'd5,
    parameter int         BOX_RADIUS = 15
) (
    input  logic                clk_65mhz,
    input  logic                rst_n,
    input  tracker_pkg::rgb_t   pixel_rgb,  // frame buffer reply one cycle after pixel_h/v
    input  logic                show_mask,
    input  logic                show_markers,
    output tracker_pkg::h_pos_t pixel_h,
    output tracker_pkg::v_pos_t pixel_v,
    output logic [3:0]          vga_r,
    output logic [3:0]          vga_g,
    output logic [3:0]          vga_b,
    output logic                vga_hs,
    output logic                vga_vs,
    output tracker_pkg::h_pos_t ball_h,
    output tracker_pkg::v_pos_t ball_v,
    output tracker_pkg::h_pos_t target_h,
    output tracker_pkg::v_pos_t target_v,
    output logic                result_valid,
    output logic                ball_low,
    output logic                ball_high,
    output logic                ball_centered
);
    import tracker_pkg::*;

    logic   hsync, vsync, blank;
    logic   hit;
    h_pos_t hit_h;
    v_pos_t hit_v;
    logic   ball_hit, target_hit, frame_done;
    logic   ball_h_ready, ball_v_ready, tgt_h_ready, tgt_v_ready;
    h_pos_t ball_h_avg, tgt_h_avg;
    v_pos_t ball_v_avg, tgt_v_avg;

    raster_timing raster0 (.clk_65mhz, .rst_n, .hcount(pixel_h), .vcount(pixel_v),
                           .hsync, .vsync, .blank);

    color_filter #(.R_LO(R_LO), .R_HI(R_HI), .G_LO(G_LO), .G_HI(G_HI),
                   .B_LO(B_LO), .B_HI(B_HI)) filter0 (
        .clk_65mhz, .rst_n, .pixel_rgb, .pixel_h, .pixel_v, .hit, .hit_h, .hit_v);

    ////////////////////
    // one accumulator per coordinate and region
    centroid_accumulator #(.pos_t(h_pos_t)) ball_h_acc (.clk_65mhz, .rst_n, .frame_done,
        .sample(ball_hit), .pos(hit_h), .ready(ball_h_ready), .avg(ball_h_avg));
    centroid_accumulator #(.pos_t(v_pos_t)) ball_v_acc (.clk_65mhz, .rst_n, .frame_done,
        .sample(ball_hit), .pos(hit_v), .ready(ball_v_ready), .avg(ball_v_avg));
    centroid_accumulator #(.pos_t(h_pos_t)) tgt_h_acc (.clk_65mhz, .rst_n, .frame_done,
        .sample(target_hit), .pos(hit_h), .ready(tgt_h_ready), .avg(tgt_h_avg));
    centroid_accumulator #(.pos_t(v_pos_t)) tgt_v_acc (.clk_65mhz, .rst_n, .frame_done,
        .sample(target_hit), .pos(hit_v), .ready(tgt_v_ready), .avg(tgt_v_avg));

    tracking_controller ctrl0 (
        .clk_65mhz, .rst_n, .hcount(pixel_h), .vcount(pixel_v), .hit, .hit_h, .hit_v,
        .ball_h_ready, .ball_v_ready, .tgt_h_ready, .tgt_v_ready,
        .ball_h_avg, .ball_v_avg, .tgt_h_avg, .tgt_v_avg,
        .ball_hit, .target_hit, .frame_done,
        .ball_h, .ball_v, .target_h, .target_v,
        .result_valid, .ball_low, .ball_high, .ball_centered);

    overlay_mixer #(.BOX_RADIUS(BOX_RADIUS)) mixer0 (
        .clk_65mhz, .rst_n, .hcount(pixel_h), .vcount(pixel_v),
        .hsync, .vsync, .blank, .pixel_rgb, .hit,
        .ball_h, .ball_v, .target_h, .target_v, .show_mask, .show_markers,
        .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs);

endmodule

//--- include/tb_tracker_ref.svh
`ifndef TB_TRACKER_REF_SVH
`define TB_TRACKER_REF_SVH

logic [31:0] lfsr_state = 32'h9016_412d;

////////////////////
// galois lfsr stepped once per bit taken
function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
        val = (val << 1) | int'(lfsr_state[0]);
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return val;
endfunction

// mode 0 puts the ball below the target, 1 above, 2 level
task automatic make_scene(input int mode);
    cur_sc[5] = 6 + take_bits(5);  // target size
    cur_sc[4] = 150 + take_bits(7);
    cur_sc[3] = TGT_LO + take_bits(8);
    cur_sc[0] = BALL_LO + take_bits(8);
    if (mode == 0) begin
        cur_sc[2] = 6 + take_bits(5);
        cur_sc[1] = cur_sc[4] + 20 + take_bits(6);
    end else if (mode == 1) begin
        cur_sc[2] = 6 + take_bits(5);
        cur_sc[1] = cur_sc[4] - 50 - take_bits(5);
    end else begin
        cur_sc[2] = cur_sc[5];  // same size, so centroids sit within a line or two
        cur_sc[1] = cur_sc[4] + take_bits(2) - 1;
    end
endtask

function automatic bit in_square(input int h, input int v, input int x0, input int y0,
                                 input int s);
    return (s > 0) && (h >= x0) && (h < x0 + s) && (v >= y0) && (v < y0 + s);
endfunction

// synthetic image of red squares on a grey background
function automatic logic [11:0] image_rgb(input int h, input int v);
    if (in_square(h, v, cur_sc[0], cur_sc[1], cur_sc[2]) ||
        in_square(h, v, cur_sc[3], cur_sc[4], cur_sc[5]))
        return 12'hF00;
    return 12'h444;
endfunction

function automatic bit colour_match(input logic [11:0] rgb);
    return (rgb[11:8] >= 4'd8) && (rgb[7:4] <= 4'd5) && (rgb[3:0] <= 4'd5);
endfunction

////////////////////
// centroid of one square clipped to its region and the camera
task automatic region_centroid(input int x0, input int y0, input int s, input int lo,
                               input int hi, output int ch, output int cv);
    int sum_h;
    int sum_v;
    int cnt;
    sum_h = 0;
    sum_v = 0;
    cnt = 0;
    for (int y = y0; y < y0 + s; y++) begin
        for (int x = x0; x < x0 + s; x++) begin
            if (x >= lo && x <= hi && y >= REG_V_LO && y <= REG_V_HI &&
                x < CAM_W && y < CAM_LINES) begin
                sum_h += x;
                sum_v += y;
                cnt++;
            end
        end
    end
    ch = (cnt == 0) ? 0 : sum_h / cnt;  // empty region reads 0
    cv = (cnt == 0) ? 0 : sum_v / cnt;
endtask

task automatic compute_reference();
    region_centroid(prev_sc[0], prev_sc[1], prev_sc[2], BALL_LO, BALL_HI, ref_bh, ref_bv);
    region_centroid(prev_sc[3], prev_sc[4], prev_sc[5], TGT_LO, TGT_HI, ref_th, ref_tv);
    ref_low  = (ref_tv + DEAD) < ref_bv;
    ref_high = (ref_bv + DEAD) < ref_tv;
    ref_cent = !ref_low && !ref_high;
endtask

function automatic bit on_box(input int h, input int v, input int ch, input int cv);
    int dh;
    int dv;
    dh = (h > ch) ? h - ch : ch - h;
    dv = (v > cv) ? v - cv : cv - v;
    return (dh <= RADIUS) && (dv <= RADIUS) && (dh == RADIUS || dv == RADIUS);
endfunction

`endif

//--- testbench/tb_tracker.sv
`timescale 1ns/1ps

module tb_tracker;

    ////////////////////
    // display and tracking constants
    localparam int H_ACT = 1024;
    localparam int H_SYNC_W = 136;
    localparam int H_TOT = 1344;
    localparam int V_ACT = 768;
    localparam int V_TOT = 806;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int CAM_W = 640;
    localparam int CAM_LINES = 480;
    localparam int BALL_LO = 20;
    localparam int BALL_HI = 319;
    localparam int TGT_LO = 320;
    localparam int TGT_HI = 639;
    localparam int REG_V_LO = 50;
    localparam int REG_V_HI = 400;
    localparam int DEAD = 2;
    localparam int RADIUS = 15;
    localparam int RESULT_LATENCY = 30;  // divider iterations plus three
    localparam int N_RESULTS = 5;

    logic        clk_65mhz = 1'b0;
    logic        rst_n = 1'b0;
    logic [11:0] pixel_rgb = 12'h000;
    logic        show_mask = 1'b0;
    logic        show_markers = 1'b1;
    logic [10:0] pixel_h, ball_h, target_h;
    logic [9:0]  pixel_v, ball_v, target_v;
    logic [3:0]  vga_r, vga_g, vga_b;
    logic        vga_hs, vga_vs;
    logic        result_valid, ball_low, ball_high, ball_centered;

    int cur_sc[6] = '{0, 0, 0, 0, 0, 0};  // ball x, y, size, target x, y, size
    int prev_sc[6];  // scene whose result is pending
    int ref_bh, ref_bv, ref_th, ref_tv;
    bit ref_low, ref_high, ref_cent;
    int scene_idx = 0;
    int errors = 0;
    int checks = 0;
    int results_seen = 0;

    `include "tb_tracker_ref.svh"

    tracker_top dut0 (
        .clk_65mhz, .rst_n, .pixel_rgb, .show_mask, .show_markers,
        .pixel_h, .pixel_v, .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs,
        .ball_h, .ball_v, .target_h, .target_v,
        .result_valid, .ball_low, .ball_high, .ball_centered);

    always #5 clk_65mhz = ~clk_65mhz;

    task automatic mismatch(input string name, input int expv, input int gotv);
        errors++;
        $display("MISMATCH %s expected %0h got %0h at %0t", name, expv, gotv, $time);
    endtask

    function automatic int expected_colour(input int h, input int v);
        if (h >= H_ACT || v >= V_ACT)
            return 0;
        if (show_mask && h < CAM_W && v < CAM_LINES && colour_match(image_rgb(h, v)))
            return 'h0F0;
        if (show_markers && on_box(h, v, ref_bh, ref_bv))
            return 'hF00;
        if (show_markers && on_box(h, v, ref_th, ref_tv))
            return 'h00F;
        if (h < CAM_W && v < CAM_LINES)
            return int'(image_rgb(h, v));
        return 0;
    endfunction

    ////////////////////
    // frame buffer model with a new scene at the top left of each frame
    always @(posedge clk_65mhz) begin
        if (rst_n && pixel_h == 11'd0 && pixel_v == 10'd0) begin
            prev_sc = cur_sc;
            compute_reference();
            scene_idx++;
            if (scene_idx <= 3)
                make_scene(scene_idx - 1);
            else
                cur_sc = '{0, 0, 0, 0, 0, 0};  // empty frame
            show_mask <= (scene_idx >= 2);
        end
        pixel_rgb <= image_rgb(int'(pixel_h), int'(pixel_v));
    end

    ////////////////////
    // compare process
    int cycle = 0;
    int frame_start = -1000;
    int hist_h[3];
    int hist_v[3];
    int hist_n = 0;
    int hs_fall = -1;
    int vs_fall = -1;
    logic last_hs = 1'b1;
    logic last_vs = 1'b1;
    int ovl_errs = 0;
    int sync_errs = 0;
    int n_low = 0;
    int n_high = 0;
    int n_cent = 0;
    int err_mark = 0;

    always @(negedge clk_65mhz) begin
        int got;
        int expv;
        int exp_h;
        int exp_v;
        if (rst_n) begin
            cycle++;
            if (cycle == 1) begin  // state left by reset
                if ({result_valid, ball_low, ball_high, ball_centered} !== 4'b0000)
                    mismatch("status", 0, int'({result_valid, ball_low, ball_high,
                                                ball_centered}));
                if ({ball_h, target_h} !== 22'd0)
                    mismatch("ball_h/target_h", 0, int'({ball_h, target_h}));
                if ({ball_v, target_v} !== 20'd0)
                    mismatch("ball_v/target_v", 0, int'({ball_v, target_v}));
                if ({vga_r, vga_g, vga_b} !== 12'h000)
                    mismatch("vga_rgb", 0, int'({vga_r, vga_g, vga_b}));
                if ({vga_hs, vga_vs} !== 2'b11)
                    mismatch("vga_hs/vga_vs", 3, int'({vga_hs, vga_vs}));
                checks += 5;
                $display("test reset state: %s", (errors == 0) ? "ok" : "errors");
                err_mark = errors;
            end

            // raster position advances one pixel per cycle and wraps at the totals
            if (hist_n > 0) begin
                exp_h = (hist_h[0] == H_TOT - 1) ? 0 : hist_h[0] + 1;
                if (hist_h[0] != H_TOT - 1)
                    exp_v = hist_v[0];
                else if (hist_v[0] == V_TOT - 1)
                    exp_v = 0;
                else
                    exp_v = hist_v[0] + 1;
                checks += 2;
                if (int'(pixel_h) != exp_h) begin
                    sync_errs++;
                    mismatch("pixel_h", exp_h, int'(pixel_h));
                end
                if (int'(pixel_v) != exp_v) begin
                    sync_errs++;
                    mismatch("pixel_v", exp_v, int'(pixel_v));
                end
            end

            // video lags the raster by three cycles
            // line 0 is left out because the markers move during it
            if (hist_n >= 3 && hist_v[2] > 0) begin
                expv = expected_colour(hist_h[2], hist_v[2]);
                got = int'({vga_r, vga_g, vga_b});
                checks++;
                if (got != expv) begin
                    ovl_errs++;
                    mismatch("vga_rgb", expv, got);
                end
            end
            hist_h[2] = hist_h[1];
            hist_v[2] = hist_v[1];
            hist_h[1] = hist_h[0];
            hist_v[1] = hist_v[0];
            hist_h[0] = int'(pixel_h);
            hist_v[0] = int'(pixel_v);
            if (hist_n < 3)
                hist_n++;

            if (pixel_h == 11'd0 && pixel_v == 10'd0)
                frame_start = cycle;

            if (result_valid) begin
                checks += 8;
                if (cycle - frame_start != RESULT_LATENCY) begin
                    errors++;
                    $display("result_valid came %0d cycles after the frame start",
                             cycle - frame_start);
                end
                if (int'(ball_h) != ref_bh)
                    mismatch("ball_h", ref_bh, int'(ball_h));
                if (int'(ball_v) != ref_bv)
                    mismatch("ball_v", ref_bv, int'(ball_v));
                if (int'(target_h) != ref_th)
                    mismatch("target_h", ref_th, int'(target_h));
                if (int'(target_v) != ref_tv)
                    mismatch("target_v", ref_tv, int'(target_v));
                if (ball_low != ref_low)
                    mismatch("ball_low", int'(ref_low), int'(ball_low));
                if (ball_high != ref_high)
                    mismatch("ball_high", int'(ref_high), int'(ball_high));
                if (ball_centered != ref_cent)
                    mismatch("ball_centered", int'(ref_cent), int'(ball_centered));
                n_low += int'(ref_low);
                n_high += int'(ref_high);
                n_cent += int'(ref_cent);
                $display("test frame %0d result (%0d,%0d) (%0d,%0d): %0d errors",
                         results_seen, ref_bh, ref_bv, ref_th, ref_tv, errors - err_mark);
                err_mark = errors;
                results_seen++;
            end

            // sync periods and width from falling edges of the active low syncs
            if (last_hs && !vga_hs) begin
                checks++;
                if (hs_fall >= 0 && cycle - hs_fall != H_TOT) begin
                    sync_errs++;
                    mismatch("vga_hs period", H_TOT, cycle - hs_fall);
                end
                hs_fall = cycle;
            end
            if (!last_hs && vga_hs && hs_fall >= 0) begin
                checks++;
                if (cycle - hs_fall != H_SYNC_W) begin
                    sync_errs++;
                    mismatch("vga_hs width", H_SYNC_W, cycle - hs_fall);
                end
            end
            if (last_vs && !vga_vs) begin
                checks++;
                if (vs_fall >= 0 && cycle - vs_fall != FRAME_CYCLES) begin
                    sync_errs++;
                    mismatch("vga_vs period", FRAME_CYCLES, cycle - vs_fall);
                end
                vs_fall = cycle;
            end
            last_hs = vga_hs;
            last_vs = vga_vs;
        end
    end

    ////////////////////
    initial begin
        int wait_cycles;
        bit timed_out;
        timed_out = 1'b0;
        repeat (5) @(posedge clk_65mhz);
        rst_n <= 1'b1;

        for (int k = 0; k < N_RESULTS && !timed_out; k++) begin
            wait_cycles = 0;
            while (results_seen <= k && wait_cycles < FRAME_CYCLES + 1000) begin
                @(posedge clk_65mhz);
                wait_cycles++;
            end
            if (results_seen <= k) begin
                $display("timeout while waiting for result_valid of frame %0d", k);
                timed_out = 1'b1;
            end
        end
        @(negedge clk_65mhz);

        $display("test raster and sync timing: %0d errors", sync_errs);
        $display("test video overlay: %0d errors", ovl_errs);
        $display("test deadband status: low %0d high %0d centered %0d", n_low, n_high,
                 n_cent);
        if (n_low == 0 || n_high == 0 || n_cent == 0)
            $display("deadband status: not every case was reached");
        $display("checks %0d, errors %0d", checks, errors);
        if (!timed_out && errors == 0 && n_low > 0 && n_high > 0 && n_cent > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tracker.f
+incdir+include
logic/tracker_pkg.sv
logic/raster_timing.sv
logic/color_filter.sv
logic/centroid_accumulator.sv
logic/tracking_controller.sv
logic/overlay_mixer.sv
logic/tracker_top.sv
testbench/tb_tracker.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_tracker
FILELIST  ?= tracker.f
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
